// File: rtl/fifo_pkg.sv
package fifo_pkg;

    // write side word and read side slice widths
    localparam int WORD_WIDTH  = 64;
    localparam int SLICE_WIDTH = 16;

    // slices per word, also the number of lane memories
    localparam int LANE_COUNT = WORD_WIDTH / SLICE_WIDTH;

    // words held by each lane
    localparam int WORD_DEPTH = 16;
    localparam int ADDR_WIDTH = 4;

    // one extra wrap bit tells full from empty
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    // slice index inside one word
    localparam int SEL_WIDTH = 2;

    // programmable flag thresholds, words on the write side and slices on the read side
    localparam int PROG_FULL_THRESH  = 12;
    localparam int PROG_EMPTY_THRESH = 8;

    typedef logic [WORD_WIDTH-1:0]            word_t;
    typedef logic [SLICE_WIDTH-1:0]           slice_t;
    typedef logic [PTR_WIDTH-1:0]             ptr_t;
    typedef logic [ADDR_WIDTH-1:0]            addr_t;
    typedef logic [PTR_WIDTH-1:0]             wr_count_t;
    typedef logic [PTR_WIDTH+SEL_WIDTH-1:0]   rd_count_t;

    // write port seen by every lane, each lane picks its own slice of data
    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } ram_wr_t;

    // read port shared by all lanes
    typedef struct packed {
        logic  en;
        addr_t addr;
    } ram_rd_t;

    // binary pointer to gray, one bit changes per step
    function automatic ptr_t bin_to_gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage

// File: rtl/gray_ptr_sync.sv
`timescale 1ns/100ps

module gray_ptr_sync (
    input  logic            clock,
    input  logic            rst,
    input  fifo_pkg::ptr_t  gray_in,
    output fifo_pkg::ptr_t  bin_out
);

    // first stage may go metastable, second one is safe to use
    fifo_pkg::ptr_t gray_meta;
    fifo_pkg::ptr_t gray_sync;

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            gray_meta <= '0;
            gray_sync <= '0;
        end else begin
            gray_meta <= gray_in;
            gray_sync <= gray_meta;
        end
    end

    // gray to binary, each bit is the xor of all gray bits above and at it
    always_comb begin
        bin_out[fifo_pkg::PTR_WIDTH-1] = gray_sync[fifo_pkg::PTR_WIDTH-1];
        for (int i = fifo_pkg::PTR_WIDTH - 2; i >= 0; i--) begin
            bin_out[i] = bin_out[i+1] ^ gray_sync[i];
        end
    end

endmodule

// File: rtl/fifo_lane_ram.sv
`timescale 1ns/100ps

module fifo_lane_ram (
    input  logic               wr_clock,
    input  logic               rd_clock,
    input  fifo_pkg::ram_wr_t  ram_wr,
    input  fifo_pkg::slice_t   lane_data,
    input  fifo_pkg::ram_rd_t  ram_rd,
    output fifo_pkg::slice_t   q
);

    // one 16-bit slice per word address
    fifo_pkg::slice_t mem [fifo_pkg::WORD_DEPTH];

    // write port on the write clock
    always_ff @(posedge wr_clock) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= lane_data;
        end
    end

    // registered read port, q keeps the last slice between reads
    always_ff @(posedge rd_clock) begin
        if (ram_rd.en) begin
            q <= mem[ram_rd.addr];
        end
    end

endmodule

// File: rtl/fifo_write_ctrl.sv
`timescale 1ns/100ps

module fifo_write_ctrl (
    input  logic                 wr_clock,
    input  logic                 rd_rst,
    input  logic                 wr_en,
    input  fifo_pkg::word_t      din,
    // read word pointer, already synchronized to wr_clock
    input  fifo_pkg::ptr_t       rd_ptr_bin,
    output fifo_pkg::ram_wr_t    ram_wr,
    output fifo_pkg::ptr_t       wr_ptr_gray,
    output logic                 full,
    output logic                 wr_ready,
    output logic                 wr_ack,
    output logic                 overflow,
    output fifo_pkg::wr_count_t  wr_data_count,
    output logic                 prog_full
);

    logic           wr_rst_meta;
    logic           wr_rst;
    fifo_pkg::ptr_t wr_ptr_bin;
    fifo_pkg::ptr_t wr_ptr_next;
    fifo_pkg::ptr_t word_diff;
    logic           wr_fire;

    // reset asserts at once, release is taken through two wr_clock flops
    always_ff @(posedge wr_clock or posedge rd_rst) begin
        if (rd_rst) begin
            wr_rst_meta <= 1'b1;
            wr_rst      <= 1'b1;
        end else begin
            wr_rst_meta <= 1'b0;
            wr_rst      <= wr_rst_meta;
        end
    end

    // full when the pointers differ only in the wrap bit
    assign full = (wr_ptr_bin == {~rd_ptr_bin[fifo_pkg::PTR_WIDTH-1],
                                  rd_ptr_bin[fifo_pkg::ADDR_WIDTH-1:0]});

    assign wr_ready = ~full;
    assign wr_fire  = wr_en & ~full;
    assign wr_ack   = wr_fire;

    // every lane sees the same enable, address and word
    assign ram_wr.en   = wr_fire;
    assign ram_wr.addr = wr_ptr_bin[fifo_pkg::ADDR_WIDTH-1:0];
    assign ram_wr.data = din;

    assign wr_ptr_next = wr_ptr_bin + fifo_pkg::ptr_t'(1);

    // binary and gray copies move together
    // gray goes out from a flop so the other domain never sees a glitch
    always_ff @(posedge wr_clock or posedge wr_rst) begin
        if (wr_rst) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
        end else if (wr_fire) begin
            wr_ptr_bin  <= wr_ptr_next;
            wr_ptr_gray <= fifo_pkg::bin_to_gray(wr_ptr_next);
        end
    end

    // modulo difference is the stored word count, 0 to 16
    assign word_diff = wr_ptr_bin - rd_ptr_bin;

    // count and prog_full share one register stage
    always_ff @(posedge wr_clock or posedge wr_rst) begin
        if (wr_rst) begin
            wr_data_count <= '0;
            prog_full     <= 1'b0;
        end else begin
            wr_data_count <= word_diff;
            prog_full     <= (int'(word_diff) >= fifo_pkg::PROG_FULL_THRESH);
        end
    end

    // rejected write request, flagged one cycle later
    always_ff @(posedge wr_clock or posedge wr_rst) begin
        if (wr_rst) begin
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en & full;
        end
    end

endmodule

// File: rtl/fifo_read_ctrl.sv
`timescale 1ns/100ps

module fifo_read_ctrl (
    input  logic                                        rd_clock,
    input  logic                                        rd_rst,
    input  logic                                        rd_en,
    // write word pointer, already synchronized to rd_clock
    input  fifo_pkg::ptr_t                              wr_ptr_bin,
    output fifo_pkg::ram_rd_t                           ram_rd,
    input  fifo_pkg::slice_t [fifo_pkg::LANE_COUNT-1:0] lane_q,
    output fifo_pkg::ptr_t                              rd_ptr_gray,
    output logic                                        valid,
    output fifo_pkg::slice_t                            dout,
    output logic                                        empty,
    output logic                                        underflow,
    output fifo_pkg::rd_count_t                         rd_data_count,
    output logic                                        prog_empty
);

    fifo_pkg::ptr_t                    rd_ptr_bin;
    fifo_pkg::ptr_t                    rd_ptr_next;
    logic [fifo_pkg::SEL_WIDTH-1:0]    rd_sel;
    logic [fifo_pkg::SEL_WIDTH-1:0]    out_sel;
    logic                              rd_fire;
    logic                              last_slice;
    fifo_pkg::ptr_t                    word_diff;
    fifo_pkg::rd_count_t               slice_count;

    // empty is judged on whole words
    // a partly read word keeps the pointers apart until its last slice
    assign empty = (rd_ptr_bin == wr_ptr_bin);

    assign rd_fire    = rd_en & ~empty;
    assign last_slice = (rd_sel == fifo_pkg::SEL_WIDTH'(fifo_pkg::LANE_COUNT - 1));

    // all lanes read the current word together
    assign ram_rd.en   = rd_fire;
    assign ram_rd.addr = rd_ptr_bin[fifo_pkg::ADDR_WIDTH-1:0];

    assign rd_ptr_next = rd_ptr_bin + fifo_pkg::ptr_t'(1);

    // slice index steps on every read, wraps to 0 after the low slice
    always_ff @(posedge rd_clock or posedge rd_rst) begin
        if (rd_rst) begin
            rd_sel <= '0;
        end else if (rd_fire) begin
            rd_sel <= rd_sel + 1'b1;
        end
    end

    // word pointer only moves once the last slice of the word is out
    always_ff @(posedge rd_clock or posedge rd_rst) begin
        if (rd_rst) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
        end else if (rd_fire && last_slice) begin
            rd_ptr_bin  <= rd_ptr_next;
            rd_ptr_gray <= fifo_pkg::bin_to_gray(rd_ptr_next);
        end
    end

    // remember which slice was asked for, it lines up with the lane outputs
    always_ff @(posedge rd_clock or posedge rd_rst) begin
        if (rd_rst) begin
            out_sel <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= rd_fire;
            if (rd_fire) begin
                out_sel <= rd_sel;
            end
        end
    end

    // lane 0 holds the top slice, so index 0 comes out first
    assign dout = lane_q[out_sel];

    // four slices per stored word, minus those already taken from the current one
    assign word_diff   = wr_ptr_bin - rd_ptr_bin;
    assign slice_count = {word_diff, {fifo_pkg::SEL_WIDTH{1'b0}}}
                         - fifo_pkg::rd_count_t'(rd_sel);

    always_ff @(posedge rd_clock or posedge rd_rst) begin
        if (rd_rst) begin
            rd_data_count <= '0;
            prog_empty    <= 1'b1;
        end else begin
            rd_data_count <= slice_count;
            prog_empty    <= (int'(slice_count) <= fifo_pkg::PROG_EMPTY_THRESH);
        end
    end

    // read request while empty, flagged one cycle later
    always_ff @(posedge rd_clock or posedge rd_rst) begin
        if (rd_rst) begin
            underflow <= 1'b0;
        end else begin
            underflow <= rd_en & empty;
        end
    end

endmodule

// File: rtl/async_downsize_fifo.sv
`timescale 1ns/100ps

module async_downsize_fifo (
    input  logic                 rd_rst,

    // write side
    input  logic                 wr_clock,
    input  logic                 wr_en,
    input  fifo_pkg::word_t      din,
    output logic                 wr_ready,
    output logic                 wr_ack,
    output logic                 full,
    output logic                 overflow,
    output fifo_pkg::wr_count_t  wr_data_count,
    output logic                 prog_full,

    // read side
    input  logic                 rd_clock,
    input  logic                 rd_en,
    output logic                 valid,
    output fifo_pkg::slice_t     dout,
    output logic                 empty,
    output logic                 underflow,
    output fifo_pkg::rd_count_t  rd_data_count,
    output logic                 prog_empty
);

    fifo_pkg::ram_wr_t                           ram_wr;
    fifo_pkg::ram_rd_t                           ram_rd;
    fifo_pkg::slice_t [fifo_pkg::LANE_COUNT-1:0] lane_q;
    fifo_pkg::ptr_t                              wr_ptr_gray;
    fifo_pkg::ptr_t                              rd_ptr_gray;
    // pointers after crossing into the other domain
    fifo_pkg::ptr_t                              wr_ptr_rd_bin;
    fifo_pkg::ptr_t                              rd_ptr_wr_bin;

    fifo_write_ctrl u_write_ctrl (
        .wr_clock      (wr_clock),
        .rd_rst        (rd_rst),
        .wr_en         (wr_en),
        .din           (din),
        .rd_ptr_bin    (rd_ptr_wr_bin),
        .ram_wr        (ram_wr),
        .wr_ptr_gray   (wr_ptr_gray),
        .full          (full),
        .wr_ready      (wr_ready),
        .wr_ack        (wr_ack),
        .overflow      (overflow),
        .wr_data_count (wr_data_count),
        .prog_full     (prog_full)
    );

    // write pointer into the read domain
    gray_ptr_sync u_wr_ptr_sync (
        .clock   (rd_clock),
        .rst     (rd_rst),
        .gray_in (wr_ptr_gray),
        .bin_out (wr_ptr_rd_bin)
    );

    // read word pointer into the write domain
    gray_ptr_sync u_rd_ptr_sync (
        .clock   (wr_clock),
        .rst     (rd_rst),
        .gray_in (rd_ptr_gray),
        .bin_out (rd_ptr_wr_bin)
    );

    // lane i stores word bits from the top down, lane 0 gets 63:48
    for (genvar i = 0; i < fifo_pkg::LANE_COUNT; i++) begin : g_lane
        fifo_lane_ram u_lane_ram (
            .wr_clock  (wr_clock),
            .rd_clock  (rd_clock),
            .ram_wr    (ram_wr),
            .lane_data (ram_wr.data[fifo_pkg::WORD_WIDTH - 1 - i * fifo_pkg::SLICE_WIDTH
                                    -: fifo_pkg::SLICE_WIDTH]),
            .ram_rd    (ram_rd),
            .q         (lane_q[i])
        );
    end

    fifo_read_ctrl u_read_ctrl (
        .rd_clock      (rd_clock),
        .rd_rst        (rd_rst),
        .rd_en         (rd_en),
        .wr_ptr_bin    (wr_ptr_rd_bin),
        .ram_rd        (ram_rd),
        .lane_q        (lane_q),
        .rd_ptr_gray   (rd_ptr_gray),
        .valid         (valid),
        .dout          (dout),
        .empty         (empty),
        .underflow     (underflow),
        .rd_data_count (rd_data_count),
        .prog_empty    (prog_empty)
    );

endmodule

// File: bench/bench_clock_gen.sv
`timescale 1ns/100ps

module bench_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clock
);

    // starts low, first rising edge after half a period
    initial clock = 1'b0;

    always #(PERIOD_NS / 2.0) clock = ~clock;

endmodule

// File: bench/async_downsize_fifo_tb.sv
`timescale 1ns/100ps

module async_downsize_fifo_tb;

    localparam int RD_PERIOD_NS  = 20;
    localparam int WR_PERIOD_NS  = 26;
    localparam int RESET_CYCLES  = 16;
    // covers both synchronizers plus the count registers
    localparam int SETTLE_CYCLES = 8;
    localparam int WAIT_LIMIT    = 64;
    localparam int MARGIN_NS     = 20000;
    localparam int ROW_COUNT     = 6;

    // what a row does beyond plain writes and reads
    localparam logic [2:0] KIND_IDLE   = 3'd0;
    localparam logic [2:0] KIND_DATA   = 3'd1;
    localparam logic [2:0] KIND_FULL   = 3'd2;
    localparam logic [2:0] KIND_EMPTY  = 3'd3;
    localparam logic [2:0] KIND_COUNT  = 3'd4;
    localparam logic [2:0] KIND_RANDOM = 3'd5;

    // one row of the test table
    typedef struct packed {
        int         words;
        int         slices;
        int         wr_gap;
        int         rd_gap;
        logic       mixed;
        logic [2:0] kind;
        // {empty, full, prog_empty, prog_full} once the row has settled
        logic [3:0] flags;
    } test_row_t;

    logic                 rd_clock;
    logic                 wr_clock;
    logic                 rd_rst;
    logic                 wr_en;
    logic                 rd_en;
    fifo_pkg::word_t      din;
    logic                 wr_ready;
    logic                 wr_ack;
    logic                 full;
    logic                 overflow;
    fifo_pkg::wr_count_t  wr_data_count;
    logic                 prog_full;
    logic                 valid;
    fifo_pkg::slice_t     dout;
    logic                 empty;
    logic                 underflow;
    fifo_pkg::rd_count_t  rd_data_count;
    logic                 prog_empty;

    test_row_t            rows [ROW_COUNT];
    string                row_name [ROW_COUNT];
    string                cur_name;
    fifo_pkg::slice_t     model_q [$];
    fifo_pkg::slice_t     expected_slice;
    logic [31:0]          rng_state;
    int                   error_count;
    int                   failed_tests;

    bench_clock_gen #(.PERIOD_NS(RD_PERIOD_NS)) rd_clock_gen_i (.clock(rd_clock));
    bench_clock_gen #(.PERIOD_NS(WR_PERIOD_NS)) wr_clock_gen_i (.clock(wr_clock));

    async_downsize_fifo dut_i (
        .rd_rst        (rd_rst),
        .wr_clock      (wr_clock),
        .wr_en         (wr_en),
        .din           (din),
        .wr_ready      (wr_ready),
        .wr_ack        (wr_ack),
        .full          (full),
        .overflow      (overflow),
        .wr_data_count (wr_data_count),
        .prog_full     (prog_full),
        .rd_clock      (rd_clock),
        .rd_en         (rd_en),
        .valid         (valid),
        .dout          (dout),
        .empty         (empty),
        .underflow     (underflow),
        .rd_data_count (rd_data_count),
        .prog_empty    (prog_empty)
    );

    task automatic flag_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("mismatch %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
        error_count++;
    endtask

    task automatic log_failure(input string msg);
        $display("error in %s: %s", cur_name, msg);
        error_count++;
    endtask

    // 32-bit xorshift, state advances on every call
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic fifo_pkg::word_t next_word();
        return {xorshift32(), xorshift32()};
    endfunction

    // fixed gap, or a random one from 0 up to the row's gap
    function automatic int pick_gap(input int gap_max, input logic random_gap);
        if (random_gap) begin
            return int'(xorshift32() % (gap_max + 1));
        end
        return gap_max;
    endfunction

    // model of the narrowing, top slice first
    task automatic push_word(input fifo_pkg::word_t word);
        fifo_pkg::word_t rest;
        rest = word;
        for (int i = 0; i < fifo_pkg::LANE_COUNT; i++) begin
            model_q.push_back(rest[fifo_pkg::WORD_WIDTH-1 -: fifo_pkg::SLICE_WIDTH]);
            rest = rest << fifo_pkg::SLICE_WIDTH;
        end
    endtask

    task automatic settle_clocks();
        repeat (SETTLE_CYCLES) @(posedge wr_clock);
    endtask

    task automatic set_row(input int idx, input string name, input logic [2:0] kind,
                           input int words, input int slices, input int wr_gap,
                           input int rd_gap, input logic mixed, input logic [3:0] flags);
        row_name[idx]      = name;
        rows[idx].kind     = kind;
        rows[idx].words    = words;
        rows[idx].slices   = slices;
        rows[idx].wr_gap   = wr_gap;
        rows[idx].rd_gap   = rd_gap;
        rows[idx].mixed    = mixed;
        rows[idx].flags    = flags;
    endtask

    task automatic load_table();
        set_row(0, "reset_idle", KIND_IDLE, 0, 0, 0, 0, 1'b0, 4'b1010);
        set_row(1, "three_words", KIND_DATA, 3, 12, 0, 0, 1'b0, 4'b1010);
        set_row(2, "fill_overflow", KIND_FULL, 16, 0, 0, 0, 1'b0, 4'b0101);
        set_row(3, "drain_underflow", KIND_EMPTY, 0, 64, 0, 1, 1'b0, 4'b1010);
        // 5 words in, 13 slices out leaves 7 slices behind
        set_row(4, "slice_counts", KIND_COUNT, 5, 13, 1, 0, 1'b0, 4'b0010);
        // 7 leftover slices plus 30 new words
        set_row(5, "random_mix", KIND_RANDOM, 30, 127, 3, 3, 1'b1, 4'b1010);
    endtask

    // data is held until wr_ack shows the word was taken
    task automatic write_words(input int count, input int gap_max, input logic random_gap);
        int              accepted;
        int              gap;
        fifo_pkg::word_t word;
        accepted = 0;
        word = next_word();
        while (accepted < count) begin
            @(posedge wr_clock);
            wr_en <= 1'b1;
            din   <= word;
            @(negedge wr_clock);
            if (wr_ack === 1'b1) begin
                push_word(word);
                accepted++;
                gap = pick_gap(gap_max, random_gap);
                if (gap > 0 || accepted == count) begin
                    @(posedge wr_clock);
                    wr_en <= 1'b0;
                    repeat (gap) @(posedge wr_clock);
                end
                word = next_word();
            end
        end
    endtask

    // a request only counts when empty is low ahead of the edge
    task automatic read_slices(input int count, input int gap_max, input logic random_gap);
        int accepted;
        int gap;
        accepted = 0;
        while (accepted < count) begin
            @(posedge rd_clock);
            rd_en <= 1'b1;
            @(negedge rd_clock);
            if (empty === 1'b0) begin
                accepted++;
                gap = pick_gap(gap_max, random_gap);
                if (gap > 0 || accepted == count) begin
                    @(posedge rd_clock);
                    rd_en <= 1'b0;
                    repeat (gap) @(posedge rd_clock);
                end
            end
        end
    endtask

    task automatic wait_full();
        int cycles;
        int words;
        cycles = 0;
        words = (model_q.size() + fifo_pkg::LANE_COUNT - 1) / fifo_pkg::LANE_COUNT;
        @(negedge wr_clock);
        while (full !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge wr_clock);
            cycles++;
        end
        if (full !== 1'b1) begin
            log_failure("full did not go high after the FIFO was filled");
        end
        if (wr_ready !== 1'b0) begin
            flag_mismatch("wr_ready while full", 32'(1'b0), 32'(wr_ready));
        end
        // count register trails the pointer
        repeat (2) @(negedge wr_clock);
        if (int'(wr_data_count) != words) begin
            flag_mismatch("wr_data_count", 32'(words), 32'(wr_data_count));
        end
        if (prog_full !== (words >= fifo_pkg::PROG_FULL_THRESH)) begin
            flag_mismatch("prog_full", 32'(words >= fifo_pkg::PROG_FULL_THRESH), 32'(prog_full));
        end
    endtask

    // this word must be dropped, so it never enters the model
    task automatic try_overflow();
        @(posedge wr_clock);
        wr_en <= 1'b1;
        din   <= next_word();
        @(negedge wr_clock);
        if (wr_ack !== 1'b0) begin
            flag_mismatch("wr_ack while full", 32'(1'b0), 32'(wr_ack));
        end
        @(posedge wr_clock);
        wr_en <= 1'b0;
        @(negedge wr_clock);
        if (overflow !== 1'b1) begin
            flag_mismatch("overflow", 32'(1'b1), 32'(overflow));
        end
    endtask

    task automatic try_underflow();
        int cycles;
        cycles = 0;
        @(negedge rd_clock);
        while (empty !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge rd_clock);
            cycles++;
        end
        if (empty !== 1'b1) begin
            log_failure("empty did not go high after all slices were read");
        end
        @(posedge rd_clock);
        rd_en <= 1'b1;
        @(posedge rd_clock);
        rd_en <= 1'b0;
        @(negedge rd_clock);
        if (underflow !== 1'b1) begin
            flag_mismatch("underflow", 32'(1'b1), 32'(underflow));
        end
        if (valid !== 1'b0) begin
            flag_mismatch("valid after empty read", 32'(1'b0), 32'(valid));
        end
    endtask

    // slice count and prog_empty follow the model depth
    task automatic compare_rd_count();
        @(negedge rd_clock);
        if (int'(rd_data_count) != model_q.size()) begin
            flag_mismatch("rd_data_count", 32'(model_q.size()), 32'(rd_data_count));
        end
        if (prog_empty !== (model_q.size() <= fifo_pkg::PROG_EMPTY_THRESH)) begin
            flag_mismatch("prog_empty", 32'(model_q.size() <= fifo_pkg::PROG_EMPTY_THRESH),
                          32'(prog_empty));
        end
    endtask

    task automatic compare_end_state(input logic [3:0] expected);
        logic [3:0] seen;
        int         words;
        // a partly read word still holds its place on the write side
        words = (model_q.size() + fifo_pkg::LANE_COUNT - 1) / fifo_pkg::LANE_COUNT;
        @(negedge wr_clock);
        seen[2] = full;
        seen[0] = prog_full;
        // wr_ready is the inverse of the expected full flag
        if (wr_ready !== !expected[2]) begin
            flag_mismatch("wr_ready", 32'(!expected[2]), 32'(wr_ready));
        end
        if (int'(wr_data_count) != words) begin
            flag_mismatch("wr_data_count", 32'(words), 32'(wr_data_count));
        end
        if (overflow !== 1'b0 || wr_ack !== 1'b0) begin
            log_failure("overflow or wr_ack high with no write request");
        end
        @(negedge rd_clock);
        seen[3] = empty;
        seen[1] = prog_empty;
        if (valid !== 1'b0 || underflow !== 1'b0) begin
            log_failure("valid or underflow high with no read request");
        end
        if (seen !== expected) begin
            flag_mismatch("flags", 32'(expected), 32'(seen));
        end
    endtask

    task automatic run_row(input int idx);
        test_row_t row;
        int        errors_before;
        row = rows[idx];
        cur_name = row_name[idx];
        errors_before = error_count;
        if (row.mixed) begin
            fork
                write_words(row.words, row.wr_gap, 1'b1);
                read_slices(row.slices, row.rd_gap, 1'b1);
            join
        end else begin
            write_words(row.words, row.wr_gap, 1'b0);
            if (row.kind == KIND_FULL) begin
                wait_full();
                try_overflow();
            end
            if (row.kind == KIND_COUNT) begin
                settle_clocks();
                compare_rd_count();
            end
            read_slices(row.slices, row.rd_gap, 1'b0);
            if (row.kind == KIND_EMPTY) begin
                try_underflow();
            end
        end
        settle_clocks();
        compare_rd_count();
        compare_end_state(row.flags);
        if (error_count == errors_before) begin
            $display("test %s: ok", cur_name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", cur_name, error_count - errors_before);
        end
    endtask

    // each valid slice must be the oldest one in the model
    always @(negedge rd_clock) begin
        if (rd_rst === 1'b0 && valid === 1'b1) begin
            if (model_q.size() == 0) begin
                log_failure("valid went high with no slice left in the model");
            end else begin
                expected_slice = model_q.pop_front();
                if (dout !== expected_slice) begin
                    flag_mismatch("dout", 32'(expected_slice), 32'(dout));
                end
            end
        end
    end

    initial begin
        int total_ops;
        int limit_ns;
        rng_state    = 32'h233b;
        rd_rst       = 1'b1;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        din          = '0;
        error_count  = 0;
        failed_tests = 0;
        cur_name     = "reset";
        load_table();
        // four slow clock cycles per table operation
        total_ops = 0;
        for (int i = 0; i < ROW_COUNT; i++) begin
            total_ops += rows[i].words + rows[i].slices;
        end
        limit_ns = total_ops * 4 * WR_PERIOD_NS + MARGIN_NS;
        fork
            begin
                #(limit_ns);
                $display("timeout: run still busy after %0d ns", limit_ns);
                $display("Result: FAILED");
                $finish;
            end
        join_none
        repeat (RESET_CYCLES) @(posedge rd_clock);
        rd_rst <= 1'b0;
        settle_clocks();
        for (int i = 0; i < ROW_COUNT; i++) begin
            run_row(i);
        end
        $display("summary: %0d tests, %0d failed, %0d errors", ROW_COUNT, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/fifo_pkg.sv
rtl/gray_ptr_sync.sv
rtl/fifo_lane_ram.sv
rtl/fifo_write_ctrl.sv
rtl/fifo_read_ctrl.sv
rtl/async_downsize_fifo.sv
bench/bench_clock_gen.sv
bench/async_downsize_fifo_tb.sv

// File: Makefile
# Verilator build and run for the dual-clock downsizing FIFO

VERILATOR ?= verilator
TOP       ?= async_downsize_fifo_tb
RTL_TOP   ?= async_downsize_fifo
LOG       ?= sim.log
FLAGS     ?= --timing
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
